/* hw/fdsu_fmt_pkg.sv */
package fdsu_fmt_pkg;

  // Datapath widths inside the pack stage
  localparam int EXPNT_W   = 13;
  // Bits 54..53 carry the rounding overflow above the leading one
  localparam int FRAC_IN_W = 55;
  localparam int FRAC52_W  = 52;
  localparam int RESULT_W  = 64;

  // IEEE field sizes
  localparam int DOUBLE_EXP_W  = 11;
  localparam int SINGLE_EXP_W  = 8;
  localparam int DOUBLE_FRAC_W = 52;
  localparam int SINGLE_FRAC_W = 23;

  // Largest right shift that still leaves a denormal bit
  localparam int DOUBLE_MAX_SHIFT = 52;
  localparam int SINGLE_MAX_SHIFT = 23;

  // Upper ones above a single result
  localparam int NAN_BOX_W = 32;

endpackage

/* hw/fdsu_kind_pkg.sv */
package fdsu_kind_pkg;

  // One-hot result class, highest priority first
  typedef enum logic [5:0] {
    RSLT_QNAN   = 6'b100000,
    RSLT_INF    = 6'b010000,
    RSLT_LFN    = 6'b001000,
    RSLT_ZERO   = 6'b000100,
    RSLT_DENORM = 6'b000010,
    RSLT_NORM   = 6'b000001
  } rslt_kind_e;

  // Exception flag word, RISC-V fflags order
  localparam int EXPT_W  = 5;
  localparam int EXPT_NV = 4;
  localparam int EXPT_DZ = 3;
  localparam int EXPT_OF = 2;
  localparam int EXPT_UF = 1;
  localparam int EXPT_NX = 0;

endpackage

/* hw/fdsu_frac_norm.sv */
`timescale 1ns/100ps

module fdsu_frac_norm (
  input  logic [fdsu_fmt_pkg::EXPNT_W-1:0]   expnt_rst,
  input  logic [fdsu_fmt_pkg::FRAC_IN_W-1:0] frac,
  output logic [fdsu_fmt_pkg::EXPNT_W-1:0]   expnt_adj,
  output logic [fdsu_fmt_pkg::FRAC52_W-1:0]  frac52
);

  localparam int TOP = fdsu_fmt_pkg::FRAC_IN_W - 1;

  logic [fdsu_fmt_pkg::EXPNT_W-1:0] expnt_add_op;

  // Leading one position decides exponent step and fraction window
  always_comb
  begin
    casez (frac[TOP -: 2])
      2'b00:
      begin
        expnt_add_op = '1;
        frac52       = frac[TOP-3 -: fdsu_fmt_pkg::FRAC52_W];
      end
      2'b01:
      begin
        expnt_add_op = '0;
        frac52       = frac[TOP-2 -: fdsu_fmt_pkg::FRAC52_W];
      end
      default:
      begin
        // Rounding carried into bit 54
        expnt_add_op = {{(fdsu_fmt_pkg::EXPNT_W-1){1'b0}}, 1'b1};
        frac52       = frac[TOP-1 -: fdsu_fmt_pkg::FRAC52_W];
      end
    endcase
  end

  assign expnt_adj = expnt_rst + expnt_add_op;

endmodule

/* hw/fdsu_denorm_shift.sv */
`timescale 1ns/100ps

module fdsu_denorm_shift #(
  parameter int FRAC_W    = 52,
  parameter int MAX_SHIFT = 52
) (
  input  logic [fdsu_fmt_pkg::EXPNT_W-1:0]   expnt_rst,
  input  logic [fdsu_fmt_pkg::FRAC_IN_W-1:0] frac,
  input  logic                               denorm_to_tiny_frac,
  output logic [FRAC_W-1:0]                  denorm_frac
);

  localparam int SRC_W = fdsu_fmt_pkg::FRAC_IN_W - 1;
  localparam logic [fdsu_fmt_pkg::EXPNT_W-1:0] SHIFT_LIMIT =
    MAX_SHIFT[fdsu_fmt_pkg::EXPNT_W-1:0];

  logic [fdsu_fmt_pkg::EXPNT_W-1:0] shift_amt;
  logic [SRC_W-1:0]                 shifted;
  logic                             in_range;

  // Shift is 1 - e, so e = 1 keeps the fraction in place
  assign shift_amt = {{(fdsu_fmt_pkg::EXPNT_W-1){1'b0}}, 1'b1} - expnt_rst;

  // Negative shifts wrap to large values and fall out of range
  assign in_range = (shift_amt <= SHIFT_LIMIT);

  assign shifted = frac[SRC_W:1] >> shift_amt;

  // Top of the 52-bit window, or the sticky lsb when shifted out
  assign denorm_frac = in_range
                     ? shifted[fdsu_fmt_pkg::FRAC52_W-1 -: FRAC_W]
                     : {{(FRAC_W-1){1'b0}}, denorm_to_tiny_frac};

endmodule

/* hw/fdsu_pack_ctrl.sv */
`timescale 1ns/100ps

module fdsu_pack_ctrl (
  input  logic                              forever_cpuclk,
  input  logic                              rst_n,
  input  logic                              ex4_vld,
  input  logic [1:0]                        frac_top,
  input  logic [1:0]                        potnt_norm,
  input  logic                              potnt_of,
  input  logic                              potnt_uf,
  input  logic                              of_rst_lfn,
  input  logic                              result_qnan,
  input  logic                              result_inf,
  input  logic                              result_lfn,
  input  logic                              result_zero,
  input  logic                              result_nor,
  input  logic                              rslt_denorm,
  input  logic                              nv,
  input  logic                              dz,
  input  logic                              of,
  input  logic                              uf,
  input  logic                              nx,
  output fdsu_kind_pkg::rslt_kind_e         rslt_kind,
  output logic                              pipe_en,
  output logic                              ex5_vld,
  output logic [fdsu_kind_pkg::EXPT_W-1:0]  ex5_expt
);

  logic                             of_plus;
  logic                             uf_plus;
  logic                             denorm_potnt_norm;
  logic [fdsu_kind_pkg::EXPT_W-1:0] expt_nxt;

  // Rounding pushed a borderline result over or under the range
  assign of_plus = potnt_of && (|frac_top) && result_nor;
  assign uf_plus = potnt_uf && !(|frac_top) && result_nor;

  // Denormal rounded up into the smallest normal
  assign denorm_potnt_norm = (potnt_norm[1] && frac_top[0]) ||
                             (potnt_norm[0] && frac_top[1]);

  always_comb
  begin
    if (result_qnan)
      rslt_kind = fdsu_kind_pkg::RSLT_QNAN;
    else if (result_inf || (of_plus && !of_rst_lfn))
      rslt_kind = fdsu_kind_pkg::RSLT_INF;
    else if (result_lfn || (of_plus && of_rst_lfn))
      rslt_kind = fdsu_kind_pkg::RSLT_LFN;
    else if (result_zero)
      rslt_kind = fdsu_kind_pkg::RSLT_ZERO;
    else if (rslt_denorm && !denorm_potnt_norm)
      rslt_kind = fdsu_kind_pkg::RSLT_DENORM;
    else
      rslt_kind = fdsu_kind_pkg::RSLT_NORM;
  end

  assign expt_nxt[fdsu_kind_pkg::EXPT_NV] = nv;
  assign expt_nxt[fdsu_kind_pkg::EXPT_DZ] = dz;
  assign expt_nxt[fdsu_kind_pkg::EXPT_OF] = of || of_plus;
  // Underflow only counts when the result is also inexact
  assign expt_nxt[fdsu_kind_pkg::EXPT_UF] = ((uf && !denorm_potnt_norm) || uf_plus) && nx;
  assign expt_nxt[fdsu_kind_pkg::EXPT_NX] = nx || of || of_plus;

  assign pipe_en = ex4_vld;

  always_ff @(posedge forever_cpuclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex5_vld  <= 1'b0;
      ex5_expt <= '0;
    end
    else
    begin
      ex5_vld <= ex4_vld;
      if (pipe_en)
        ex5_expt <= expt_nxt;
    end
  end

endmodule

/* hw/fdsu_result_form.sv */
`timescale 1ns/100ps

module fdsu_result_form (
  input  logic                                   forever_cpuclk,
  input  logic                                   rst_n,
  input  logic                                   pipe_en,
  input  logic                                   double,
  input  fdsu_kind_pkg::rslt_kind_e              rslt_kind,
  input  logic                                   result_sign,
  input  logic                                   qnan_sign,
  input  logic [fdsu_fmt_pkg::DOUBLE_FRAC_W-1:0] qnan_f,
  input  logic [fdsu_fmt_pkg::EXPNT_W-1:0]       expnt_adj,
  input  logic [fdsu_fmt_pkg::FRAC52_W-1:0]      frac52,
  input  logic [fdsu_fmt_pkg::DOUBLE_FRAC_W-1:0] double_denorm_frac,
  input  logic [fdsu_fmt_pkg::SINGLE_FRAC_W-1:0] single_denorm_frac,
  output logic [fdsu_fmt_pkg::RESULT_W-1:0]      ex5_result
);

  localparam int DEW  = fdsu_fmt_pkg::DOUBLE_EXP_W;
  localparam int SEW  = fdsu_fmt_pkg::SINGLE_EXP_W;
  localparam int DFW  = fdsu_fmt_pkg::DOUBLE_FRAC_W;
  localparam int SFW  = fdsu_fmt_pkg::SINGLE_FRAC_W;
  localparam int BOXW = fdsu_fmt_pkg::NAN_BOX_W;
  localparam int RW   = fdsu_fmt_pkg::RESULT_W;

  logic [RW-1:0] rst_lfn;
  logic [RW-1:0] rst_zero;
  logic [RW-1:0] rst_qnan;
  logic [RW-1:0] rst_inf;
  logic [RW-1:0] rst_norm;
  logic [RW-1:0] rst_denorm;
  logic [RW-1:0] rst_nxt;

  // Largest finite has the exponent one below all ones
  assign rst_lfn = double
    ? {result_sign, {(DEW-1){1'b1}}, 1'b0, {DFW{1'b1}}}
    : {{BOXW{1'b1}}, result_sign, {(SEW-1){1'b1}}, 1'b0, {SFW{1'b1}}};

  assign rst_zero = double
    ? {result_sign, {(RW-1){1'b0}}}
    : {{BOXW{1'b1}}, result_sign, {(RW-BOXW-1){1'b0}}};

  // Quiet bit forced, payload from the low fraction bits
  assign rst_qnan = double
    ? {qnan_sign, {DEW{1'b1}}, 1'b1, qnan_f[DFW-2:0]}
    : {{BOXW{1'b1}}, qnan_sign, {SEW{1'b1}}, 1'b1, qnan_f[SFW-2:0]};

  assign rst_inf = double
    ? {result_sign, {DEW{1'b1}}, {DFW{1'b0}}}
    : {{BOXW{1'b1}}, result_sign, {SEW{1'b1}}, {SFW{1'b0}}};

  assign rst_norm = double
    ? {result_sign, expnt_adj[DEW-1:0], frac52}
    : {{BOXW{1'b1}}, result_sign, expnt_adj[SEW-1:0],
       frac52[fdsu_fmt_pkg::FRAC52_W-1 -: SFW]};

  assign rst_denorm = double
    ? {result_sign, {DEW{1'b0}}, double_denorm_frac}
    : {{BOXW{1'b1}}, result_sign, {SEW{1'b0}}, single_denorm_frac};

  always_comb
  begin
    case (rslt_kind)
      fdsu_kind_pkg::RSLT_QNAN:   rst_nxt = rst_qnan;
      fdsu_kind_pkg::RSLT_INF:    rst_nxt = rst_inf;
      fdsu_kind_pkg::RSLT_LFN:    rst_nxt = rst_lfn;
      fdsu_kind_pkg::RSLT_ZERO:   rst_nxt = rst_zero;
      fdsu_kind_pkg::RSLT_DENORM: rst_nxt = rst_denorm;
      default:                    rst_nxt = rst_norm;
    endcase
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n)
  begin
    if (!rst_n)
      ex5_result <= '0;
    else if (pipe_en)
      ex5_result <= rst_nxt;
  end

endmodule

/* hw/fdsu_pack.sv */
`timescale 1ns/100ps

module fdsu_pack (
  input  logic                                   forever_cpuclk,
  input  logic                                   rst_n,
  input  logic                                   ex4_vld,
  input  logic                                   double,
  input  logic [fdsu_fmt_pkg::EXPNT_W-1:0]       expnt_rst,
  input  logic [fdsu_fmt_pkg::FRAC_IN_W-1:0]     frac,
  input  logic [1:0]                             potnt_norm,
  input  logic                                   potnt_of,
  input  logic                                   potnt_uf,
  input  logic                                   of_rst_lfn,
  input  logic                                   denorm_to_tiny_frac,
  input  logic                                   result_qnan,
  input  logic                                   result_inf,
  input  logic                                   result_lfn,
  input  logic                                   result_zero,
  input  logic                                   result_nor,
  input  logic                                   rslt_denorm,
  input  logic                                   result_sign,
  input  logic                                   qnan_sign,
  input  logic [fdsu_fmt_pkg::DOUBLE_FRAC_W-1:0] qnan_f,
  input  logic                                   nv,
  input  logic                                   dz,
  input  logic                                   of,
  input  logic                                   uf,
  input  logic                                   nx,
  output logic                                   ex5_vld,
  output logic [fdsu_fmt_pkg::RESULT_W-1:0]      ex5_result,
  output logic [fdsu_kind_pkg::EXPT_W-1:0]       ex5_expt
);

  logic [fdsu_fmt_pkg::EXPNT_W-1:0]       expnt_adj;
  logic [fdsu_fmt_pkg::FRAC52_W-1:0]      frac52;
  logic [fdsu_fmt_pkg::DOUBLE_FRAC_W-1:0] double_denorm_frac;
  logic [fdsu_fmt_pkg::SINGLE_FRAC_W-1:0] single_denorm_frac;
  fdsu_kind_pkg::rslt_kind_e              rslt_kind;
  logic                                   pipe_en;

  fdsu_frac_norm u_frac_norm (
    .expnt_rst (expnt_rst),
    .frac      (frac),
    .expnt_adj (expnt_adj),
    .frac52    (frac52)
  );

  // Denormal shifters run on the unadjusted exponent
  fdsu_denorm_shift #(
    .FRAC_W    (fdsu_fmt_pkg::DOUBLE_FRAC_W),
    .MAX_SHIFT (fdsu_fmt_pkg::DOUBLE_MAX_SHIFT)
  ) u_double_denorm (
    .expnt_rst           (expnt_rst),
    .frac                (frac),
    .denorm_to_tiny_frac (denorm_to_tiny_frac),
    .denorm_frac         (double_denorm_frac)
  );

  fdsu_denorm_shift #(
    .FRAC_W    (fdsu_fmt_pkg::SINGLE_FRAC_W),
    .MAX_SHIFT (fdsu_fmt_pkg::SINGLE_MAX_SHIFT)
  ) u_single_denorm (
    .expnt_rst           (expnt_rst),
    .frac                (frac),
    .denorm_to_tiny_frac (denorm_to_tiny_frac),
    .denorm_frac         (single_denorm_frac)
  );

  fdsu_pack_ctrl u_pack_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .ex4_vld        (ex4_vld),
    .frac_top       (frac[fdsu_fmt_pkg::FRAC_IN_W-1 -: 2]),
    .potnt_norm     (potnt_norm),
    .potnt_of       (potnt_of),
    .potnt_uf       (potnt_uf),
    .of_rst_lfn     (of_rst_lfn),
    .result_qnan    (result_qnan),
    .result_inf     (result_inf),
    .result_lfn     (result_lfn),
    .result_zero    (result_zero),
    .result_nor     (result_nor),
    .rslt_denorm    (rslt_denorm),
    .nv             (nv),
    .dz             (dz),
    .of             (of),
    .uf             (uf),
    .nx             (nx),
    .rslt_kind      (rslt_kind),
    .pipe_en        (pipe_en),
    .ex5_vld        (ex5_vld),
    .ex5_expt       (ex5_expt)
  );

  fdsu_result_form u_result_form (
    .forever_cpuclk     (forever_cpuclk),
    .rst_n              (rst_n),
    .pipe_en            (pipe_en),
    .double             (double),
    .rslt_kind          (rslt_kind),
    .result_sign        (result_sign),
    .qnan_sign          (qnan_sign),
    .qnan_f             (qnan_f),
    .expnt_adj          (expnt_adj),
    .frac52             (frac52),
    .double_denorm_frac (double_denorm_frac),
    .single_denorm_frac (single_denorm_frac),
    .ex5_result         (ex5_result)
  );

endmodule

/* dv/fdsu_pack_props.sv */
`timescale 1ns/100ps

module fdsu_pack_props (
  input logic                             forever_cpuclk,
  input logic                             rst_n,
  input logic                             ex4_vld,
  input logic                             ex5_vld,
  input logic [fdsu_kind_pkg::EXPT_W-1:0] ex5_expt
);

  // Valid stays low while reset is held
  vld_low_in_reset: assert property (@(posedge forever_cpuclk)
    (!rst_n && $past(!rst_n)) |-> !ex5_vld)
    else $error("ex5_vld high during reset");

  // One register stage from strobe to valid
  vld_one_cycle: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    $past(rst_n) |-> (ex5_vld == $past(ex4_vld)))
    else $error("ex5_vld does not follow ex4_vld by one cycle");

  // Overflow always comes with inexact
  of_has_nx: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    ex5_expt[fdsu_kind_pkg::EXPT_OF] |-> ex5_expt[fdsu_kind_pkg::EXPT_NX])
    else $error("overflow flag set without inexact");

endmodule

bind fdsu_pack fdsu_pack_props u_props (.*);

/* dv/fdsu_pack_tb.sv */
`timescale 1ns/100ps

module fdsu_pack_tb;

  localparam int NUM_ITEMS  = 2000;
  localparam int MAX_CYCLES = 20000;
  localparam int DRAIN_MAX  = 16;

  logic                                   forever_cpuclk;
  logic                                   rst_n;
  logic                                   ex4_vld;
  logic                                   double;
  logic [fdsu_fmt_pkg::EXPNT_W-1:0]       expnt_rst;
  logic [fdsu_fmt_pkg::FRAC_IN_W-1:0]     frac;
  logic [1:0]                             potnt_norm;
  logic                                   potnt_of;
  logic                                   potnt_uf;
  logic                                   of_rst_lfn;
  logic                                   denorm_to_tiny_frac;
  logic                                   result_qnan;
  logic                                   result_inf;
  logic                                   result_lfn;
  logic                                   result_zero;
  logic                                   result_nor;
  logic                                   rslt_denorm;
  logic                                   result_sign;
  logic                                   qnan_sign;
  logic [fdsu_fmt_pkg::DOUBLE_FRAC_W-1:0] qnan_f;
  logic                                   nv;
  logic                                   dz;
  logic                                   of;
  logic                                   uf;
  logic                                   nx;
  logic                                   ex5_vld;
  logic [fdsu_fmt_pkg::RESULT_W-1:0]      ex5_result;
  logic [fdsu_kind_pkg::EXPT_W-1:0]       ex5_expt;

  integer                                 seed;
  logic [63:0]                            res_q[$];
  logic [4:0]                             expt_q[$];
  logic [63:0]                            held_result;
  logic [4:0]                             held_expt;
  int                                     sent;
  int                                     cycles;

  fdsu_pack dut (.*);

  always #2 forever_cpuclk = ~forever_cpuclk;

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
      fail_run();
    end
  endtask

  // Double word, or a single with 32 ones above it
  function automatic logic [63:0] assemble(input logic sign, input logic [10:0] expo,
                                           input logic [51:0] man);
    if (double)
      return {sign, expo, man};
    else
      return {{fdsu_fmt_pkg::NAN_BOX_W{1'b1}}, sign, expo[7:0], man[22:0]};
  endfunction

  function automatic logic [63:0] model_result();
    logic        of_plus;
    logic        dn_norm;
    logic [12:0] adj;
    logic [51:0] f52;
    logic [53:0] shifted;
    logic [51:0] dn;
    int          sh;
    of_plus = potnt_of && (frac[54:53] != 2'b00) && result_nor;
    dn_norm = (potnt_norm[1] && frac[53]) || (potnt_norm[0] && frac[54]);
    adj     = expnt_rst + (frac[54] ? 13'd1 : (frac[53] ? 13'd0 : 13'h1fff));
    f52     = frac[54] ? frac[53:2] : (frac[53] ? frac[52:1] : frac[51:0]);
    // Denormal shift of 1 - e on the unadjusted exponent
    sh = 1 - int'($signed(expnt_rst));
    if (sh >= 0 && sh <= (double ? 52 : 23))
    begin
      shifted = frac[54:1] >> sh;
      dn      = double ? shifted[51:0] : {29'd0, shifted[51:29]};
    end
    else
      dn = {51'd0, denorm_to_tiny_frac};
    if (result_qnan)
      return assemble(qnan_sign, 11'h7ff,
                      double ? {1'b1, qnan_f[50:0]} : {29'd0, 1'b1, qnan_f[21:0]});
    else if (result_inf || (of_plus && !of_rst_lfn))
      return assemble(result_sign, 11'h7ff, 52'd0);
    else if (result_lfn || of_plus)
      return assemble(result_sign, 11'h7fe, {52{1'b1}});
    else if (result_zero)
      return assemble(result_sign, 11'd0, 52'd0);
    else if (rslt_denorm && !dn_norm)
      return assemble(result_sign, 11'd0, dn);
    else
      return assemble(result_sign, adj[10:0], double ? f52 : {29'd0, f52[51:29]});
  endfunction

  function automatic logic [4:0] model_expt();
    logic       of_plus;
    logic       uf_plus;
    logic       dn_norm;
    logic [4:0] e;
    of_plus = potnt_of && (frac[54:53] != 2'b00) && result_nor;
    uf_plus = potnt_uf && (frac[54:53] == 2'b00) && result_nor;
    dn_norm = (potnt_norm[1] && frac[53]) || (potnt_norm[0] && frac[54]);
    e[fdsu_kind_pkg::EXPT_NV] = nv;
    e[fdsu_kind_pkg::EXPT_DZ] = dz;
    e[fdsu_kind_pkg::EXPT_OF] = of || of_plus;
    e[fdsu_kind_pkg::EXPT_UF] = ((uf && !dn_norm) || uf_plus) && nx;
    e[fdsu_kind_pkg::EXPT_NX] = nx || of || of_plus;
    return e;
  endfunction

  task automatic drive_inputs(input logic allow);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [3:0]  pick;
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    c = {$random(seed), $random(seed)};
    ex4_vld             = allow && (|a[15:14]);
    double              = a[0];
    result_sign         = a[1];
    qnan_sign           = a[2];
    of_rst_lfn          = a[3];
    denorm_to_tiny_frac = a[4];
    potnt_norm          = a[6:5];
    potnt_of            = a[7];
    potnt_uf            = a[8];
    {nv, dz, of, uf, nx} = a[13:9];
    // Mostly one class at a time
    // Pick 14 sets no class and 15 sets zero and normal together
    pick        = a[19:16];
    result_qnan = (pick == 4'd0);
    result_inf  = (pick == 4'd1);
    result_lfn  = (pick == 4'd2);
    result_zero = (pick == 4'd3) || (pick == 4'd15);
    rslt_denorm = (pick >= 4'd4) && (pick <= 4'd7);
    result_nor  = ((pick >= 4'd8) && (pick <= 4'd13)) || (pick == 4'd15);
    // Half the exponents land near the denormal window
    if (a[20])
      expnt_rst = 13'd4 - {7'd0, a[26:21]};
    else
      expnt_rst = a[39:27];
    frac   = b[54:0];
    qnan_f = c[51:0];
    if (ex4_vld)
    begin
      res_q.push_back(model_result());
      expt_q.push_back(model_expt());
    end
  endtask

  // Outputs must match the item strobed one cycle ago, or hold
  task automatic check_outputs();
    if (ex5_vld)
    begin
      if (res_q.size() == 0)
      begin
        $display("ERROR: ex5_vld is high with no item in flight");
        fail_run();
      end
      held_result = res_q.pop_front();
      held_expt   = expt_q.pop_front();
    end
    else if (res_q.size() != 0)
    begin
      $display("ERROR: no result one cycle after an accepted strobe");
      fail_run();
    end
    compare("ex5_result", ex5_result, held_result);
    compare("ex5_expt", 64'(ex5_expt), 64'(held_expt));
  endtask

  initial
  begin
    seed           = 32'ha225_b81e;
    held_result    = '0;
    held_expt      = '0;
    forever_cpuclk = 1'b0;
    rst_n          = 1'b0;
    drive_inputs(1'b0);
    repeat (16) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    compare("ex5_vld", 64'(ex5_vld), 64'd0);
    rst_n  = 1'b1;
    sent   = 0;
    cycles = 0;
    while (sent < NUM_ITEMS)
    begin
      @(negedge forever_cpuclk);
      check_outputs();
      drive_inputs(1'b1);
      if (ex4_vld)
        sent++;
      cycles++;
      if (cycles > MAX_CYCLES)
      begin
        $display("ERROR: stimulus loop timed out after %0d cycles", cycles);
        fail_run();
      end
    end
    // Drain the last item and idle a few cycles
    cycles = 0;
    while (res_q.size() != 0 || cycles < 4)
    begin
      @(negedge forever_cpuclk);
      check_outputs();
      drive_inputs(1'b0);
      cycles++;
      if (cycles > DRAIN_MAX)
      begin
        $display("ERROR: pipeline did not drain within %0d cycles", DRAIN_MAX);
        fail_run();
      end
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

/* sim.f */
hw/fdsu_fmt_pkg.sv
hw/fdsu_kind_pkg.sv
hw/fdsu_frac_norm.sv
hw/fdsu_denorm_shift.sv
hw/fdsu_pack_ctrl.sv
hw/fdsu_result_form.sv
hw/fdsu_pack.sv
dv/fdsu_pack_props.sv
dv/fdsu_pack_tb.sv

/* Makefile */
TOP := fdsu_pack_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
